// File: src/csc_sync_pkg.sv
package csc_sync_pkg;

  // ----------------------------------------------------------
  // Frame markers carried by the CFEB fiber links
  // ----------------------------------------------------------

  // The eight valid K-words all have bits 4..1 equal to hex E
  typedef enum logic [7:0] {
    k_bc       = 8'hBC,  // Most common marker
    k_1c       = 8'h1C,
    k_3c       = 8'h3C,
    k_5c       = 8'h5C,
    k_7c       = 8'h7C,
    k_9c       = 8'h9C,
    k_dc       = 8'hDC,
    k_fd       = 8'hFD,
    k_overflow = 8'hFC   // Overflow marker, excluded from the sync check
  } kchar_e;

  localparam int n_markers = 8;  // Size of the valid marker table

  // Valid markers in their code order, BC is index 0
  localparam kchar_e marker_table [n_markers] = '{
    k_bc, k_1c, k_3c, k_5c, k_7c, k_9c, k_dc, k_fd
  };

  localparam logic [3:0] table_nibble = 4'hE;  // Common value of bits 4..1 of a valid marker

  localparam int delay_w    = 4;              // Width of the resync-done delay setting
  localparam int sync_depth = 2 ** delay_w;  // Depth of the resync-done delay line

  // One link as seen in one bunch crossing
  typedef struct packed {
    logic [7:0] kchar;         // Received frame marker
    logic       link_good;     // Link reports good lock
    logic       fiber_enable;  // Fiber is enabled for this link
    logic       sync_done;     // TTC resync has completed on this link
  } link_sample_t;

  // Qualified view of one link handed to the monitor
  typedef struct packed {
    logic [7:0] kchar;     // Marker passed through unchanged
    logic       skip;      // Link takes no part in the comparison
    logic       in_table;  // Marker is valid or the link is skipped
  } link_qual_t;

  // Power-up reset controller states
  typedef enum logic [1:0] {
    st_wait_lock,
    st_power_delay,
    st_run
  } rst_state_e;

endpackage

// File: src/sync_reset_ctrl.sv
module sync_reset_ctrl #(
  parameter int power_up_delay = 2  // Cycles spent in st_power_delay after clock lock
) (
  input  logic clock,
  input  logic rst_n,
  input  logic clk_lock,
  input  logic global_reset,
  input  logic ttc_resync,
  output logic ready
);
  import csc_sync_pkg::*;

  localparam int cnt_w = $clog2(power_up_delay + 1);  // Counter wide enough for the delay

  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(power_up_delay - 1);  // Final count value

  rst_state_e        state;  // Controller state
  logic [cnt_w-1:0]  cnt;    // Power-up delay counter

  // ----------------------------------------------------------
  // Power-up state machine
  // ----------------------------------------------------------

  // Losing clock lock in any state restarts the power-up sequence
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= st_wait_lock;
      cnt   <= '0;
    end else if (!clk_lock) begin
      state <= st_wait_lock;  // Lock dropped so wait for it again
      cnt   <= '0;
    end else begin
      case (state)
        st_wait_lock: begin
          state <= st_power_delay;  // Lock seen, start counting
          cnt   <= '0;
        end
        st_power_delay: begin
          if (cnt == cnt_last) begin
            state <= st_run;  // Delay has run out
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_run:  state <= st_run;  // Stay here until lock is lost
        default: state <= st_wait_lock;
      endcase
    end
  end

  // Run-ready is held off for any cycle with a global reset or a TTC resync
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= (state == st_run) && !global_reset && !ttc_resync;
    end
  end

endmodule

// File: src/link_qualifier.sv
module link_qualifier (
  input  logic                      clock,
  input  logic                      rst_n,
  input  csc_sync_pkg::link_sample_t sample,
  output csc_sync_pkg::link_qual_t   qual
);
  import csc_sync_pkg::*;

  logic good_r1;  // link_good one cycle ago
  logic good_r2;  // link_good two cycles ago
  logic skip;     // Link is left out of the sync check

  // ----------------------------------------------------------
  // Link-good history
  // ----------------------------------------------------------

  // A link must have been good two cycles back as well as now
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      good_r1 <= 1'b0;
      good_r2 <= 1'b0;
    end else begin
      good_r1 <= sample.link_good;
      good_r2 <= good_r1;
    end
  end

  // ----------------------------------------------------------
  // Skip decision and marker check
  // ----------------------------------------------------------

  // Overflow, a bad or recently bad link, or a disabled fiber all skip the link
  always_comb begin
    skip = (sample.kchar == k_overflow)
        || !sample.link_good
        || !good_r2
        || !sample.fiber_enable;
  end

  // A skipped link counts as in the table so it never flags a bad marker
  always_comb begin
    qual.kchar    = sample.kchar;
    qual.skip     = skip;
    qual.in_table = (sample.kchar[4:1] == table_nibble) || skip;
  end

endmodule

// File: src/sync_done_delay.sv
module sync_done_delay #(
  parameter int n_links = 5  // Number of CFEB links
) (
  input  logic                       clock,
  input  logic                       rst_n,
  input  csc_sync_pkg::link_sample_t samples [n_links],
  input  logic [csc_sync_pkg::delay_w-1:0] delay,
  output logic                       done_dly
);
  import csc_sync_pkg::*;

  logic                 all_done;          // Every link has finished its resync
  logic [sync_depth:1]  done_sr;           // done_sr[k] is all_done from k cycles back
  logic [delay_w:0]     tap;               // Selected stage, one more than the setting

  // ----------------------------------------------------------
  // Combined resync-done flag
  // ----------------------------------------------------------

  always_comb begin
    all_done = 1'b1;
    for (int i = 0; i < n_links; i++) begin
      all_done = all_done & samples[i].sync_done;  // One missing link holds the flag low
    end
  end

  // ----------------------------------------------------------
  // Delay line
  // ----------------------------------------------------------

  // The line starts empty so the flag reads low until fresh history arrives
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      done_sr <= '0;
    end else begin
      done_sr <= {done_sr[sync_depth-1:1], all_done};
    end
  end

  assign tap      = {1'b0, delay} + 1'b1;  // Setting 0 gives one cycle, 15 gives sixteen
  assign done_dly = done_sr[tap];

endmodule

// File: src/csc_sync_mon.sv
module csc_sync_mon #(
  parameter int n_links = 5  // Number of CFEB links
) (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     ready,
  input  logic                     done_dly,
  input  csc_sync_pkg::link_qual_t quals [n_links],
  output logic                     cfebs_synced,
  output logic                     cfebs_lostsync
);
  import csc_sync_pkg::*;

  logic [7:0] or_k;          // OR of the markers of the non-skipped links
  logic [7:0] and_k;         // AND of the same markers
  logic       all_skip;      // No link takes part in the check
  logic       all_in_table;  // Every link carries a valid marker or is skipped
  logic       in_sync;       // Combined sync decision for this cycle
  logic       clear;         // Monitor is held in its idle state

  // ----------------------------------------------------------
  // Cross-link marker comparison
  // ----------------------------------------------------------

  // OR and AND of a set of bytes agree only when every byte is the same
  always_comb begin
    or_k         = '0;
    and_k        = '1;
    all_skip     = 1'b1;
    all_in_table = 1'b1;
    for (int i = 0; i < n_links; i++) begin
      // Skipped links force zero into the OR and ones into the AND
      or_k         = or_k  | (quals[i].kchar & {8{~quals[i].skip}});
      and_k        = and_k & (quals[i].kchar | {8{quals[i].skip}});
      all_skip     = all_skip & quals[i].skip;
      all_in_table = all_in_table & quals[i].in_table;
    end
  end

  // With every link skipped there is nothing to disagree about
  assign in_sync = ((or_k == and_k) && all_in_table) || all_skip;

  // Not running yet, or a resync still settling on some link
  assign clear = !ready || !done_dly;

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!rst_n || clear) begin
      cfebs_synced   <= 1'b1;  // Report synced while idle
      cfebs_lostsync <= 1'b0;  // Idle also wipes the lost-sync history
    end else begin
      cfebs_synced   <= in_sync;
      cfebs_lostsync <= cfebs_lostsync | ~in_sync;  // Sticky until the next clear
    end
  end

endmodule

// File: src/csc_sync_top.sv
module csc_sync_top #(
  parameter int n_links        = 5,  // Number of CFEB links
  parameter int power_up_delay = 2   // Power-up delay after clock lock in cycles
) (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             clk_lock,
  input  logic                             global_reset,
  input  logic                             ttc_resync,
  input  csc_sync_pkg::link_sample_t       link_in [n_links],
  input  logic [csc_sync_pkg::delay_w-1:0] rxd_int_delay,
  output logic                             cfebs_synced,
  output logic                             cfebs_lostsync
);
  import csc_sync_pkg::*;

  logic       ready;            // Run-ready from the reset controller
  logic       done_dly;         // Delayed all-links resync-done flag
  link_qual_t quals [n_links];  // Qualified view of each link

  // ----------------------------------------------------------
  // Run-ready generation
  // ----------------------------------------------------------

  sync_reset_ctrl #(
    .power_up_delay (power_up_delay)
  ) u_reset_ctrl (
    .clock        (clock),
    .rst_n        (rst_n),
    .clk_lock     (clk_lock),
    .global_reset (global_reset),
    .ttc_resync   (ttc_resync),
    .ready        (ready)
  );

  // One qualifier per fiber link
  for (genvar i = 0; i < n_links; i++) begin : g_link
    link_qualifier u_qual (
      .clock  (clock),
      .rst_n  (rst_n),
      .sample (link_in[i]),
      .qual   (quals[i])
    );
  end

  sync_done_delay #(
    .n_links (n_links)
  ) u_done_delay (
    .clock    (clock),
    .rst_n    (rst_n),
    .samples  (link_in),
    .delay    (rxd_int_delay),
    .done_dly (done_dly)
  );

  // Comparison and output registers
  csc_sync_mon #(
    .n_links (n_links)
  ) u_mon (
    .clock          (clock),
    .rst_n          (rst_n),
    .ready          (ready),
    .done_dly       (done_dly),
    .quals          (quals),
    .cfebs_synced   (cfebs_synced),
    .cfebs_lostsync (cfebs_lostsync)
  );

endmodule

// File: test/csc_sync_assert.sv
module csc_sync_assert (
  input logic clock,
  input logic rst_n,
  input logic clear,           // Monitor hold from ready and done_dly
  input logic cfebs_synced,
  input logic cfebs_lostsync
);
  timeunit 1ns;
  timeprecision 100ps;

  logic hold;  // Output registers are forced to their idle values

  assign hold = !rst_n || clear;

  // ------------------------------------------------------------
  // Monitor output rules
  // ------------------------------------------------------------

  // A held cycle leaves the outputs idle on the next edge
  a_hold_idle: assert property (@(posedge clock) hold |=> (cfebs_synced && !cfebs_lostsync))
    else $error("Outputs not idle after a hold cycle");

  // Lost-sync is sticky and only a hold can bring it down
  a_lost_fall: assert property (@(posedge clock) $fell(cfebs_lostsync) |-> $past(hold))
    else $error("cfebs_lostsync fell without a hold");

  // An out-of-sync cycle must be remembered unless a hold wipes it
  a_lost_set: assert property (@(posedge clock) (!cfebs_synced && !hold) |=> cfebs_lostsync)
    else $error("cfebs_lostsync not set after an out-of-sync cycle");

endmodule

// Attach the checks to every monitor instance
bind csc_sync_mon csc_sync_assert u_assert (
  .clock          (clock),
  .rst_n          (rst_n),
  .clear          (clear),
  .cfebs_synced   (cfebs_synced),
  .cfebs_lostsync (cfebs_lostsync)
);

// File: test/csc_sync_tb.sv
module csc_sync_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import csc_sync_pkg::*;

  localparam int n_links = 5;             // Links on the DUT
  localparam int hold_cycles = 24;        // Settling time allowed for every row
  localparam logic [n_links-1:0] on5 = '1;  // Every link set

  // The eight valid markers, index drawn from the LFSR
  localparam kchar_e valid_k [8] = '{k_bc, k_1c, k_3c, k_5c, k_7c, k_9c, k_dc, k_fd};

  // One table row with the stimulus of all links and the expected outputs
  typedef struct packed {
    logic [n_links-1:0][7:0] kchar;  // Marker per link
    logic [n_links-1:0]      good;   // link_good per link
    logic [n_links-1:0]      fen;    // fiber_enable per link
    logic [n_links-1:0]      sdone;  // sync_done per link
    logic [2:0]              ctl;    // {clk_lock, global_reset, ttc_resync}
    logic [delay_w-1:0]      dly;    // rxd_int_delay
    logic                    rnd;    // Common marker comes from the LFSR
    logic [1:0]              exp;    // {cfebs_synced, cfebs_lostsync}
  } row_t;

  logic               clock;
  logic               rst_n;
  logic               clk_lock;
  logic               global_reset;
  logic               ttc_resync;
  link_sample_t       link_in [n_links];
  logic [delay_w-1:0] rxd_int_delay;
  logic               cfebs_synced;
  logic               cfebs_lostsync;

  row_t       rows [$];  // Stimulus table
  logic [7:0] lfsr;      // Fibonacci LFSR state

  csc_sync_top #(
    .n_links        (n_links),
    .power_up_delay (2)
  ) dut (
    .clock          (clock),
    .rst_n          (rst_n),
    .clk_lock       (clk_lock),
    .global_reset   (global_reset),
    .ttc_resync     (ttc_resync),
    .link_in        (link_in),
    .rxd_int_delay  (rxd_int_delay),
    .cfebs_synced   (cfebs_synced),
    .cfebs_lostsync (cfebs_lostsync)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // Taps 8, 6, 5 and 4 give a maximal length sequence
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // Three output bits, one LFSR step each
  task automatic draw_index(output logic [2:0] idx);
    for (int b = 0; b < 3; b++) begin
      idx  = {idx[1:0], lfsr[7]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [n_links-1:0][7:0] all_k(input logic [7:0] k);
    return {n_links{k}};
  endfunction

  // Every link carries base except link idx
  function automatic logic [n_links-1:0][7:0] one_off(input logic [7:0] base, input int idx,
                                                      input logic [7:0] other);
    logic [n_links-1:0][7:0] ks;
    for (int i = 0; i < n_links; i++) begin
      ks[i] = (i == idx) ? other : base;
    end
    return ks;
  endfunction

  task automatic add_row(input logic [n_links-1:0][7:0] ks, input logic [n_links-1:0] good,
                         input logic [n_links-1:0] fen, input logic [n_links-1:0] sdone,
                         input logic [2:0] ctl, input logic [delay_w-1:0] dly,
                         input logic rnd, input logic [1:0] exp);
    row_t r;
    r = '{kchar: ks, good: good, fen: fen, sdone: sdone, ctl: ctl, dly: dly, rnd: rnd, exp: exp};
    rows.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    logic [2:0] idx;
    logic [7:0] common;
    common = 8'h00;
    if (r.rnd) begin
      draw_index(idx);
      common = valid_k[idx];  // Same random marker on all links
    end
    for (int i = 0; i < n_links; i++) begin
      link_in[i].kchar        = r.rnd ? common : r.kchar[i];
      link_in[i].link_good    = r.good[i];
      link_in[i].fiber_enable = r.fen[i];
      link_in[i].sync_done    = r.sdone[i];
    end
    {clk_lock, global_reset, ttc_resync} = r.ctl;
    rxd_int_delay = r.dly;
  endtask

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_row(input int n, input row_t r);
    assert (cfebs_synced === r.exp[1]) else begin
      $display("[FAIL] row %0d cfebs_synced expected %h got %h", n, r.exp[1], cfebs_synced);
      stop_run();
    end
    assert (cfebs_lostsync === r.exp[0]) else begin
      $display("[FAIL] row %0d cfebs_lostsync expected %h got %h", n, r.exp[0], cfebs_lostsync);
      stop_run();
    end
  endtask

  // ------------------------------------------------------------
  // Table and stimulus loop
  // ------------------------------------------------------------

  initial begin
    int cycles;
    rst_n         = 1'b0;
    clk_lock      = 1'b1;
    global_reset  = 1'b0;
    ttc_resync    = 1'b0;
    rxd_int_delay = '0;
    lfsr          = 8'h08;  // Seed
    for (int i = 0; i < n_links; i++) begin
      link_in[i] = '0;
    end

    // The first row differs from the idle outputs so the first wait sees the DUT run
    add_row(one_off(k_bc, 2, k_3c), on5, on5, on5, 3'b100, 4'd2, 1'b0, 2'b01);
    add_row(all_k(k_bc), on5, on5, on5, 3'b100, 4'd2, 1'b0, 2'b11);  // Lost-sync stays
    add_row(all_k(k_bc), on5, on5, on5, 3'b101, 4'd2, 1'b0, 2'b10);  // TTC resync clears
    add_row(all_k(k_bc), on5, on5, on5, 3'b100, 4'd2, 1'b0, 2'b10);  // Matched BC
    add_row(all_k(k_bc), on5, on5, on5, 3'b100, 4'd2, 1'b1, 2'b10);
    add_row(one_off(k_bc, 4, k_5c), on5, 5'h0F, on5, 3'b100, 4'd2, 1'b0, 2'b10);
    add_row(one_off(k_bc, 1, k_7c), 5'h1D, on5, on5, 3'b100, 4'd2, 1'b0, 2'b10);
    add_row(one_off(k_bc, 3, k_overflow), on5, on5, on5, 3'b100, 4'd2, 1'b0, 2'b10);
    add_row({8'hFD, 8'hDC, 8'h9C, 8'h7C, 8'h5C}, on5, 5'h00, on5, 3'b100, 4'd2, 1'b0, 2'b10);
    add_row(all_k(8'hF7), on5, on5, on5, 3'b100, 4'd2, 1'b0, 2'b01);  // Not a marker
    add_row(all_k(k_bc), on5, on5, on5, 3'b110, 4'd2, 1'b0, 2'b10);  // Global reset
    add_row(all_k(8'h00), on5, on5, on5, 3'b100, 4'd2, 1'b0, 2'b01);
    add_row(all_k(k_bc), on5, on5, on5, 3'b000, 4'd2, 1'b0, 2'b10);  // Clock lock lost
    add_row(all_k(k_bc), on5, on5, on5, 3'b100, 4'd2, 1'b0, 2'b10);
    add_row(one_off(k_bc, 0, k_9c), on5, on5, on5, 3'b100, 4'd2, 1'b0, 2'b01);
    add_row(all_k(k_bc), on5, on5, 5'h17, 3'b100, 4'd2, 1'b0, 2'b10);  // Link 3 not done
    add_row(all_k(k_bc), on5, on5, on5, 3'b100, 4'd0, 1'b1, 2'b10);  // Shortest delay
    add_row(one_off(k_bc, 4, k_dc), on5, on5, on5, 3'b100, 4'd0, 1'b0, 2'b01);
    add_row(all_k(k_bc), on5, on5, on5, 3'b100, 4'd0, 1'b0, 2'b11);
    add_row(all_k(k_bc), on5, on5, 5'h1E, 3'b100, 4'd15, 1'b0, 2'b10);  // Longest delay
    add_row(all_k(k_bc), on5, on5, on5, 3'b100, 4'd15, 1'b1, 2'b10);
    add_row(one_off(k_bc, 1, k_fd), on5, on5, on5, 3'b100, 4'd15, 1'b0, 2'b01);
    add_row(all_k(k_bc), on5, on5, on5, 3'b100, 4'd15, 1'b0, 2'b11);

    repeat (4) @(posedge clock);
    #10 rst_n = 1'b1;

    for (int n = 0; n < rows.size(); n++) begin
      apply_row(rows[n]);
      if (n == 0) begin
        // Bounded wait for the first result after reset
        cycles = 0;
        while ({cfebs_synced, cfebs_lostsync} !== rows[0].exp && cycles < hold_cycles) begin
          @(posedge clock);
          #10;
          cycles++;
        end
        if ({cfebs_synced, cfebs_lostsync} !== rows[0].exp) begin
          $display("Timeout: the outputs never settled after the first row");
          stop_run();
        end
      end
      repeat (hold_cycles) @(posedge clock);
      #10;  // Outputs are registered and stable here
      check_row(n, rows[n]);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: list.f
src/csc_sync_pkg.sv
src/sync_reset_ctrl.sv
src/link_qualifier.sv
src/sync_done_delay.sv
src/csc_sync_mon.sv
src/csc_sync_top.sv
test/csc_sync_assert.sv
test/csc_sync_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module csc_sync_tb -f list.f -o csc_sync_sim

out=$(./obj_dir/csc_sync_sim 2>&1) || true
echo "$out"

# Exit status follows the search for the pass line
echo "$out" | grep -q "^STATUS: PASS$"
